// File: arb_cfg_pkg.sv
/* Arbiter sizing constants */
package arb_cfg_pkg;

  // Number of requesters, sets req, gnt and pointer widths
  localparam int N_REQ = 16;

  // Carry-lookahead group size
  localparam int LAH = 4;

  // Lookahead groups across the full request vector
  localparam int N_GRP = N_REQ / LAH;

  // Requester index width
  localparam int IDX_W = $clog2(N_REQ);

endpackage

// File: arb_ctrl_pkg.sv
/* Arbiter control definitions */
package arb_ctrl_pkg;

  // Pointer update policy
  typedef enum logic [1:0] {
    MODE_ROUND_ROBIN = 2'd0, // pointer moves to one past the winner
    MODE_FIXED       = 2'd1, // pointer pinned at requester 0
    MODE_FREEZE      = 2'd2  // pointer keeps its value
  } arb_mode_e;

  // Pointer index after reset
  localparam logic [arb_cfg_pkg::IDX_W-1:0] PTR_RESET = '0;

endpackage

// File: arbiter_checker.sv
/* Arbiter port assertions */
`timescale 1ns/1ps

module arbiter_checker (
  input logic                          clk,
  input logic                          reset,
  input logic [arb_cfg_pkg::N_REQ-1:0] req,
  input logic                          arb_en,
  input logic [arb_cfg_pkg::N_REQ-1:0] gnt,
  input logic                          gnt_valid
);

  // At most one winner per decision
  a_gnt_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(gnt))
    else $error("gnt has more than one bit set: %h", gnt);

  a_valid_match: assert property (@(posedge clk) disable iff (reset)
    gnt_valid == (gnt != '0))
    else $error("gnt_valid %b does not match gnt %h", gnt_valid, gnt);

  // Granted bit must come from an enabled request one cycle back
  a_gnt_requested: assert property (@(posedge clk) disable iff (reset)
    (gnt != '0) |-> ($past(arb_en) && ((gnt & ~$past(req)) == '0)))
    else $error("gnt %h was not requested with arb_en in the previous cycle", gnt);

endmodule

// File: arbiter_input.txt
# name arb_en mode req_hex exp_gnt_hex
# mode 0 round robin 1 fixed 2 freeze
rot_00 1 0 ffff 0001
rot_01 1 0 ffff 0002
rot_02 1 0 ffff 0004
rot_03 1 0 ffff 0008
rot_04 1 0 ffff 0010
rot_05 1 0 ffff 0020
rot_06 1 0 ffff 0040
rot_07 1 0 ffff 0080
rot_08 1 0 ffff 0100
rot_09 1 0 ffff 0200
rot_10 1 0 ffff 0400
rot_11 1 0 ffff 0800
rot_12 1 0 ffff 1000
rot_13 1 0 ffff 2000
rot_14 1 0 ffff 4000
rot_15 1 0 ffff 8000
rot_wrap 1 0 ffff 0001
wrap_hi 1 0 0100 0100
wrap_lo 1 0 0006 0002
fix_a 1 1 00f0 0010
fix_b 1 1 8421 0001
fix_c 1 1 0011 0001
frz_set 1 0 0040 0040
frz_a 1 2 0881 0080
frz_b 1 2 0881 0080
frz_c 1 2 0801 0800
en_low 0 0 ffff 0000
zero_req 1 0 0000 0000
after_idle 1 0 ffff 0080

// File: arbiter_scoreboard.sv
/* Arbiter scoreboard and reference model */
`timescale 1ns/1ps

module arbiter_scoreboard #(
  parameter int NAME_W = 128
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          vec_valid,
  input  logic [NAME_W-1:0]             vec_name,
  input  logic                          has_exp,
  input  logic [arb_cfg_pkg::N_REQ-1:0] exp_gnt,
  input  logic [arb_cfg_pkg::N_REQ-1:0] req,
  input  logic                          arb_en,
  input  arb_ctrl_pkg::arb_mode_e       mode,
  input  logic [arb_cfg_pkg::N_REQ-1:0] gnt,
  input  logic [arb_cfg_pkg::IDX_W-1:0] gnt_index,
  input  logic                          gnt_valid,
  input  logic                          no_req,
  output int                            checked_count,
  output int                            fail_count
);

  import arb_cfg_pkg::*;
  import arb_ctrl_pkg::*;

  logic [IDX_W-1:0]  ptr_model;
  logic              pending;
  logic              pend_bad;
  logic [NAME_W-1:0] pend_name;
  logic [N_REQ-1:0]  pend_gnt;
  logic [N_REQ-1:0]  model_gnt;
  logic [IDX_W-1:0]  exp_idx;
  logic              bad;
  int                n_checked;
  int                n_failed;

  // Scan upward from the pointer, wrapping past the top
  function automatic logic [N_REQ-1:0] predict_grant(input logic [N_REQ-1:0] r,
                                                     input logic [IDX_W-1:0] start);
    logic [N_REQ-1:0] result;
    logic [IDX_W-1:0] idx;
    logic             found;
    result = '0;
    found  = 1'b0;
    for (int i = 0; i < N_REQ; i++) begin
      idx = start + IDX_W'(i);
      if (!found && r[idx]) begin
        result[idx] = 1'b1;
        found       = 1'b1;
      end
    end
    return result;
  endfunction

  function automatic logic [IDX_W-1:0] index_of(input logic [N_REQ-1:0] g);
    logic [IDX_W-1:0] idx;
    idx = '0;
    for (int i = 0; i < N_REQ; i++) begin
      if (g[i]) idx = IDX_W'(i);
    end
    return idx;
  endfunction

  function automatic logic [IDX_W-1:0] next_ptr(input arb_mode_e m,
                                                input logic [IDX_W-1:0] cur,
                                                input logic [N_REQ-1:0] win);
    case (m)
      MODE_ROUND_ROBIN: return index_of(win) + IDX_W'(1);
      MODE_FIXED:       return PTR_RESET;
      default:          return cur;
    endcase
  endfunction

  always @(posedge clk) begin
    if (reset) begin
      ptr_model     = PTR_RESET;
      pending       = 1'b0;
      n_checked     = 0;
      n_failed      = 0;
      checked_count <= 0;
      fail_count    <= 0;
    end else begin
      // Outputs now hold the decision sampled one edge ago
      if (pending) begin
        exp_idx = index_of(pend_gnt);
        bad     = pend_bad;
        if (gnt !== pend_gnt) begin
          $display("Mismatch %s gnt expected %h actual %h", pend_name, pend_gnt, gnt);
          bad = 1'b1;
        end
        if (gnt_index !== exp_idx) begin
          $display("Mismatch %s gnt_index expected %0d actual %0d",
                   pend_name, exp_idx, gnt_index);
          bad = 1'b1;
        end
        if (gnt_valid !== (|pend_gnt)) begin
          $display("Mismatch %s gnt_valid expected %b actual %b",
                   pend_name, |pend_gnt, gnt_valid);
          bad = 1'b1;
        end
        n_checked++;
        if (bad) n_failed++;
        $display("%s %s", bad ? "FAIL" : "ok  ", pend_name);
      end

      pending = vec_valid;
      if (vec_valid) begin
        model_gnt = arb_en ? predict_grant(req, ptr_model) : '0;
        pend_gnt  = has_exp ? exp_gnt : model_gnt;
        pend_name = vec_name;
        pend_bad  = 1'b0;
        if (has_exp && model_gnt !== exp_gnt) begin
          $display("Data file grant for %s disagrees with the reference model", vec_name);
          pend_bad = 1'b1;
        end
        if (no_req !== (req == '0)) begin
          $display("Mismatch %s no_req expected %b actual %b", vec_name, req == '0, no_req);
          pend_bad = 1'b1;
        end
        if (arb_en && req != '0) ptr_model = next_ptr(mode, ptr_model, model_gnt);
      end
      checked_count <= n_checked;
      fail_count    <= n_failed;
    end
  end

endmodule

// File: fast_ppe.sv
/* Fast programmable priority encoder */
`timescale 1ns/1ps

module fast_ppe (
  input  logic [arb_cfg_pkg::N_REQ-1:0] req,
  input  logic [arb_cfg_pkg::N_REQ-1:0] prio,
  output logic [arb_cfg_pkg::N_REQ-1:0] grant_next,
  output logic                          no_req
);

  import arb_cfg_pkg::*;

  logic [N_REQ-1:0] gnt_smpl;
  logic [N_REQ-1:0] gnt_masked;
  logic             cout_smpl;
  logic             cout_masked;

  if (N_GRP * LAH != N_REQ) begin : g_grp_chk
    $error("N_REQ %0d is not a multiple of LAH %0d", N_REQ, LAH);
  end

  // Lowest requester overall
  ppe_lookahead #(
    .W(N_REQ),
    .G(LAH)
  ) smpl_ppe_inst (
    .r   (req),
    .p   ('0),
    .cin (1'b1),
    .g   (gnt_smpl),
    .cout(cout_smpl)
  );

  // Lowest requester at or above the pointer, no wrap
  ppe_lookahead #(
    .W(N_REQ),
    .G(LAH)
  ) masked_ppe_inst (
    .r   (req),
    .p   (prio),
    .cin (1'b0),
    .g   (gnt_masked),
    .cout(cout_masked)
  );

  // Masked miss falls back to the simple chain, giving the wrap
  assign grant_next = cout_masked ? gnt_smpl : gnt_masked;
  assign no_req     = cout_smpl;

endmodule

// File: ppe_lookahead.sv
/* Lookahead programmable priority encoder */
`timescale 1ns/1ps

module ppe_lookahead #(
  parameter int W = arb_cfg_pkg::N_REQ,
  parameter int G = arb_cfg_pkg::LAH
) (
  input  logic [W-1:0] r,
  input  logic [W-1:0] p,
  input  logic         cin,
  output logic [W-1:0] g,
  output logic         cout
);

  import arb_cfg_pkg::*;

  localparam int NG = W / G;

  logic [NG:0] c; // Carry into each group

  if ((W % G) != 0 || W > N_REQ) begin : g_size_chk
    $error("ppe_lookahead bad sizing W=%0d G=%0d N_REQ=%0d", W, G, N_REQ);
  end

  assign c[0] = cin;

  for (genvar k = 0; k < NG; k++) begin : g_grp
    logic [G-1:0] r_grp;
    logic [G-1:0] p_grp;
    logic         grp_gen;
    logic         grp_prop;

    assign r_grp = r[k*G +: G];
    assign p_grp = p[k*G +: G];

    // Generate: some priority bit sees no request at or above it
    always_comb begin
      grp_gen = 1'b0;
      for (int j = 0; j < G; j++) begin
        if (p_grp[j] && !(|(r_grp >> j))) begin
          grp_gen = 1'b1;
        end
      end
    end

    assign grp_prop = ~(|r_grp); // Idle group passes the carry through

    assign c[k+1] = grp_gen | (grp_prop & c[k]);

    // Group carry out is rebuilt by the lookahead terms above
    ppe_ripple #(
      .W(G)
    ) ppe_ripple_inst (
      .r   (r_grp),
      .p   (p_grp),
      .cin (c[k]),
      .g   (g[k*G +: G]),
      .cout()
    );
  end

  // G equal to W collapses this to a single ripple chain
  assign cout = c[NG];

endmodule

// File: ppe_ripple.sv
/* Ripple programmable priority chain */
`timescale 1ns/1ps

module ppe_ripple #(
  parameter int W = arb_cfg_pkg::LAH
) (
  input  logic [W-1:0] r,
  input  logic [W-1:0] p,
  input  logic         cin,
  output logic [W-1:0] g,
  output logic         cout
);

  import arb_cfg_pkg::*;

  logic [W:0]   carry;
  logic [W-1:0] armed;

  // A chain wider than the request vector is a sizing mistake
  if (W > N_REQ) begin : g_width_chk
    $error("ppe_ripple width %0d exceeds N_REQ %0d", W, N_REQ);
  end

  assign carry[0] = cin;

  for (genvar k = 0; k < W; k++) begin : g_slice
    // Armed by its own priority bit or by the carry from below
    assign armed[k] = p[k] | carry[k];

    assign g[k] = r[k] & armed[k];

    // Search continues only past an idle, armed slice
    assign carry[k+1] = armed[k] & ~r[k];
  end

  assign cout = carry[W]; // High when nothing granted in the chain

endmodule

// File: rr_arbiter_top.sv
/* Round-robin arbiter top */
`timescale 1ns/1ps

module rr_arbiter_top (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [arb_cfg_pkg::N_REQ-1:0] req,
  input  logic                          arb_en,
  input  arb_ctrl_pkg::arb_mode_e       mode,
  output logic [arb_cfg_pkg::N_REQ-1:0] gnt,
  output logic [arb_cfg_pkg::IDX_W-1:0] gnt_index,
  output logic                          gnt_valid,
  output logic                          no_req
);

  import arb_cfg_pkg::*;

  logic [N_REQ-1:0] prio;       // One-hot pointer
  logic [N_REQ-1:0] grant_next; // Combinational decision

  // Wrap-around search, zero cycles
  fast_ppe fast_ppe_inst (
    .req       (req),
    .prio      (prio),
    .grant_next(grant_next),
    .no_req    (no_req)
  );

  // Decision registered on arb_en, one cycle latency
  rr_grant_state rr_grant_state_inst (
    .clk       (clk),
    .reset     (reset),
    .arb_en    (arb_en),
    .mode      (mode),
    .grant_next(grant_next),
    .prio      (prio),
    .gnt       (gnt),
    .gnt_index (gnt_index),
    .gnt_valid (gnt_valid)
  );

endmodule

// File: rr_grant_state.sv
/* Grant registers and priority pointer */
`timescale 1ns/1ps

module rr_grant_state (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          arb_en,
  input  arb_ctrl_pkg::arb_mode_e       mode,
  input  logic [arb_cfg_pkg::N_REQ-1:0] grant_next,
  output logic [arb_cfg_pkg::N_REQ-1:0] prio,
  output logic [arb_cfg_pkg::N_REQ-1:0] gnt,
  output logic [arb_cfg_pkg::IDX_W-1:0] gnt_index,
  output logic                          gnt_valid
);

  import arb_cfg_pkg::*;
  import arb_ctrl_pkg::*;

  logic [IDX_W-1:0] ptr;
  logic [IDX_W-1:0] win_index;
  logic             win_any;

  // One-hot to binary index of the winner
  always_comb begin
    win_index = '0;
    for (int i = 0; i < N_REQ; i++) begin
      if (grant_next[i]) begin
        win_index = win_index | IDX_W'(i);
      end
    end
  end

  assign win_any = |grant_next;

  always_ff @(posedge clk) begin
    if (reset) begin
      gnt       <= '0;
      gnt_index <= '0;
      gnt_valid <= 1'b0;
      ptr       <= PTR_RESET;
    end else begin
      gnt       <= arb_en ? grant_next : '0; // No carry-over of requests
      gnt_index <= arb_en ? win_index : '0;
      gnt_valid <= arb_en & win_any;

      if (arb_en && win_any) begin
        case (mode)
          MODE_ROUND_ROBIN: ptr <= win_index + IDX_W'(1); // Wraps 15 to 0
          MODE_FIXED:       ptr <= PTR_RESET;
          default:          ptr <= ptr;
        endcase
      end
    end
  end

  // Pointer index to one-hot priority
  always_comb begin
    prio      = '0;
    prio[ptr] = 1'b1;
  end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the arbiter testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert --top-module tb_rr_arbiter \
  -f vlog.f -Mdir "$BUILD_DIR" -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "tests failed" "$LOG_FILE"; then
  exit 1
fi
if ! grep -q "all tests passed" "$LOG_FILE"; then
  echo "No final report found in $LOG_FILE"
  exit 1
fi
exit 0

// File: tb_rr_arbiter.sv
/* Round-robin arbiter testbench */
`timescale 1ns/1ps

module tb_rr_arbiter;

  import arb_cfg_pkg::*;
  import arb_ctrl_pkg::*;

  localparam int    NAME_W     = 8 * 16;
  localparam int    N_RANDOM   = 24;
  localparam string INPUT_FILE = "arbiter_input.txt";

  logic             clk;
  logic             reset;
  logic [N_REQ-1:0] req;
  logic             arb_en;
  arb_mode_e        mode;
  logic [N_REQ-1:0] gnt;
  logic [IDX_W-1:0] gnt_index;
  logic             gnt_valid;
  logic             no_req;

  // Test tag that travels with each driven vector
  logic              vec_valid;
  logic [NAME_W-1:0] vec_name;
  logic              has_exp;
  logic [N_REQ-1:0]  exp_gnt;

  logic [NAME_W-1:0] name_q[$];
  logic              en_q[$];
  arb_mode_e         mode_q[$];
  logic [N_REQ-1:0]  req_q[$];
  logic [N_REQ-1:0]  gnt_q[$];
  logic              has_exp_q[$];

  int checked_count;
  int fail_count;
  int load_errors = 0;
  int vec_total   = 0;
  int cycle_limit = 0;
  int cycle_count = 0;

  rr_arbiter_top rr_arbiter_top_inst (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .arb_en   (arb_en),
    .mode     (mode),
    .gnt      (gnt),
    .gnt_index(gnt_index),
    .gnt_valid(gnt_valid),
    .no_req   (no_req)
  );

  arbiter_scoreboard #(
    .NAME_W(NAME_W)
  ) arbiter_scoreboard_inst (
    .clk          (clk),
    .reset        (reset),
    .vec_valid    (vec_valid),
    .vec_name     (vec_name),
    .has_exp      (has_exp),
    .exp_gnt      (exp_gnt),
    .req          (req),
    .arb_en       (arb_en),
    .mode         (mode),
    .gnt          (gnt),
    .gnt_index    (gnt_index),
    .gnt_valid    (gnt_valid),
    .no_req       (no_req),
    .checked_count(checked_count),
    .fail_count   (fail_count)
  );

  bind rr_arbiter_top arbiter_checker arbiter_checker_inst (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .arb_en   (arb_en),
    .gnt      (gnt),
    .gnt_valid(gnt_valid)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic load_vectors();
    int                fd;
    int                n_fields;
    logic [8*96-1:0]   line_buf;
    logic [NAME_W-1:0] nm;
    logic              en;
    logic [1:0]        md;
    logic [N_REQ-1:0]  rq;
    logic [N_REQ-1:0]  eg;
    fd = $fopen(INPUT_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open stimulus file %s", INPUT_FILE);
      load_errors++;
    end else begin
      line_buf = '0;
      while ($fgets(line_buf, fd) != 0) begin
        nm       = '0;
        n_fields = $sscanf(line_buf, "%s %h %h %h %h", nm, en, md, rq, eg);
        if (n_fields == 5) begin // Header and blank lines fall through
          name_q.push_back(nm);
          en_q.push_back(en);
          mode_q.push_back(arb_mode_e'(md));
          req_q.push_back(rq);
          gnt_q.push_back(eg);
          has_exp_q.push_back(1'b1);
        end
        line_buf = '0;
      end
      $fclose(fd);
      if (name_q.size() == 0) begin
        $display("No vectors found in stimulus file %s", INPUT_FILE);
        load_errors++;
      end
    end
  endtask

  // Round-robin traffic, predicted by the scoreboard model
  task automatic add_random_vectors();
    logic [NAME_W-1:0] nm;
    for (int i = 0; i < N_RANDOM; i++) begin
      nm = '0;
      $sformat(nm, "rand_%02d", i);
      name_q.push_back(nm);
      en_q.push_back(1'b1);
      mode_q.push_back(MODE_ROUND_ROBIN);
      req_q.push_back(N_REQ'($urandom & $urandom)); // Sparse requests
      gnt_q.push_back({N_REQ{1'b0}});
      has_exp_q.push_back(1'b0);
    end
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Timeout after %0d cycles with %0d of %0d tests checked",
               cycle_count, checked_count, vec_total);
      $display("tests failed");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'h178cc6e3));
    reset     = 1'b1;
    req       = '0;
    arb_en    = 1'b0;
    mode      = MODE_ROUND_ROBIN;
    vec_valid = 1'b0;
    vec_name  = '0;
    has_exp   = 1'b0;
    exp_gnt   = '0;

    load_vectors();
    add_random_vectors();
    vec_total   = name_q.size();
    cycle_limit = vec_total * 4 + 50;

    repeat (3) @(posedge clk);
    reset <= 1'b0;

    for (int i = 0; i < vec_total; i++) begin
      @(posedge clk);
      req       <= req_q[i];
      arb_en    <= en_q[i];
      mode      <= mode_q[i];
      vec_valid <= 1'b1;
      vec_name  <= name_q[i];
      has_exp   <= has_exp_q[i];
      exp_gnt   <= gnt_q[i];
    end
    @(posedge clk);
    vec_valid <= 1'b0;
    arb_en    <= 1'b0;
    req       <= '0;

    while (checked_count < vec_total) @(posedge clk);

    $display("Summary: %0d checked, %0d passed, %0d failed",
             checked_count, checked_count - fail_count, fail_count);
    if (load_errors == 0 && fail_count == 0 && checked_count == vec_total) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
arb_cfg_pkg.sv
arb_ctrl_pkg.sv
ppe_ripple.sv
ppe_lookahead.sv
fast_ppe.sv
rr_grant_state.sv
rr_arbiter_top.sv
arbiter_checker.sv
arbiter_scoreboard.sv
tb_rr_arbiter.sv
